//--- flist.f
nf_pkg.sv
nf_control_unit.sv
nf_sign_ex.sv
nf_branch_unit.sv
nf_i_du.sv
nf_alu.sv
nf_reg_file.sv
nf_cpu.sv
nf_cpu_checker.sv
nf_cpu_asserts.sv
tb_nf_cpu.sv

//--- nf_alu.sv
`timescale 1ns/1ps

module nf_alu
(
    input   logic   [31 : 0]    src_a,
    input   logic   [31 : 0]    src_b,
    input   logic   [4  : 0]    shift,      // shift amount, separate from src_b
    input   logic   [3  : 0]    alu_code,
    output  logic   [31 : 0]    result
);

    import nf_pkg::*;

    always_comb begin
        case (alu_code)
            ALU_ADD  : result = src_a + src_b;
            ALU_SUB  : result = src_a - src_b;
            ALU_AND  : result = src_a & src_b;
            ALU_OR   : result = src_a | src_b;
            ALU_XOR  : result = src_a ^ src_b;
            ALU_SLL  : result = src_a << shift;
            ALU_SRL  : result = src_a >> shift;
            ALU_SRA  : result = $unsigned($signed(src_a) >>> shift);    // keeps sign bit
            ALU_SLT  : result = { 31'b0, $signed(src_a) < $signed(src_b) };
            ALU_SLTU : result = { 31'b0, src_a < src_b };
            default  : result = '0;
        endcase
    end

endmodule : nf_alu

//--- nf_branch_unit.sv
`timescale 1ns/1ps

module nf_branch_unit
(
    input   logic   [2  : 0]    branch_type,
    input   logic   [31 : 0]    d1,         // rs1 value
    input   logic   [31 : 0]    d2,         // rs2 value
    input   logic   [0  : 0]    branch_hf,  // invert compare
    output  logic   [0  : 0]    pc_src      // 1 = take target
);

    import nf_pkg::*;

    logic   equal;
    logic   less;                           // signed
    logic   less_u;                         // unsigned
    logic   cond;

    assign equal  = (d1 == d2);
    assign less   = ($signed(d1) < $signed(d2));
    assign less_u = (d1 < d2);

    always_comb begin
        case (branch_type)
            BR_EQ   : cond = equal;
            BR_LT   : cond = less;
            BR_LTU  : cond = less_u;
            default : cond = 1'b0;
        endcase
    end

    // jumps always taken, none never
    assign pc_src = (branch_type == BR_JUMP) ? 1'b1 :
                    (branch_type == BR_NONE) ? 1'b0 : (cond ^ branch_hf);

endmodule : nf_branch_unit

//--- nf_control_unit.sv
`timescale 1ns/1ps

module nf_control_unit
(
    input   logic   [6 : 0]     opcode,         // major opcode
    input   logic   [2 : 0]     funct3,
    input   logic   [6 : 0]     funct7,         // only bit 5 matters here
    output  logic   [0 : 0]     src_b_sel,      // 1 = immediate
    output  logic   [1 : 0]     src_a_sel,
    output  logic   [0 : 0]     shift_sel,      // 1 = rd2[4:0], 0 = shamt
    output  logic   [0 : 0]     res_sel,        // 1 = link value pc+4
    output  logic   [2 : 0]     branch_type,
    output  logic   [0 : 0]     branch_hf,
    output  logic   [0 : 0]     branch_src,     // 1 = rd1 base (jalr)
    output  logic   [0 : 0]     we_rf,
    output  logic   [2 : 0]     imm_src,
    output  logic   [3 : 0]     alu_code
);

    import nf_pkg::*;

    // funct3 to alu code, alt picks sub / sra
    function automatic logic [3 : 0] alu_dec(input logic [2 : 0] f3, input logic alt);
        logic [3 : 0] code;
        case (f3)
            3'b000  : code = alt ? ALU_SUB : ALU_ADD;
            3'b001  : code = ALU_SLL;
            3'b010  : code = ALU_SLT;
            3'b011  : code = ALU_SLTU;
            3'b100  : code = ALU_XOR;
            3'b101  : code = alt ? ALU_SRA : ALU_SRL;
            3'b110  : code = ALU_OR;
            default : code = ALU_AND;
        endcase
        return code;
    endfunction

    always_comb begin
        // defaults describe a nop
        src_b_sel   = 1'b0;
        src_a_sel   = SRCA_RD1;
        shift_sel   = 1'b0;
        res_sel     = 1'b0;
        branch_type = BR_NONE;
        branch_hf   = 1'b0;
        branch_src  = 1'b0;
        we_rf       = 1'b0;
        imm_src     = IMM_I;
        alu_code    = ALU_ADD;
        case (opcode)
            OPC_OP : begin
                we_rf     = 1'b1;
                shift_sel = 1'b1;                       // shift by rs2
                alu_code  = alu_dec(funct3, funct7[5]);
            end
            OPC_OP_IMM : begin
                we_rf     = 1'b1;
                src_b_sel = 1'b1;
                // funct7[5] is immediate data except on srai
                alu_code  = alu_dec(funct3, funct7[5] && (funct3 == 3'b101));
            end
            OPC_LUI, OPC_AUIPC : begin
                we_rf     = 1'b1;
                src_b_sel = 1'b1;
                imm_src   = IMM_U;
                src_a_sel = (opcode == OPC_LUI) ? SRCA_ZERO : SRCA_PC;
            end
            OPC_BRANCH : begin
                imm_src   = IMM_B;
                branch_hf = funct3[0];                  // bne, bge, bgeu
                case (funct3[2 : 1])
                    2'b00   : branch_type = BR_EQ;
                    2'b10   : branch_type = BR_LT;
                    2'b11   : branch_type = BR_LTU;
                    default : branch_type = BR_NONE;    // 010/011 unused
                endcase
            end
            OPC_JAL : begin
                we_rf       = 1'b1;
                res_sel     = 1'b1;
                branch_type = BR_JUMP;
                imm_src     = IMM_J;
            end
            OPC_JALR : begin
                we_rf       = 1'b1;
                res_sel     = 1'b1;
                branch_type = BR_JUMP;
                branch_src  = 1'b1;
            end
            default : ;                                 // unsupported, falls to pc+4
        endcase
    end

endmodule : nf_control_unit

//--- nf_cpu.sv
`timescale 1ns/1ps

module nf_cpu
(
    input   logic   [0  : 0]    clk,
    input   logic   [0  : 0]    rst_n,
    input   logic   [31 : 0]    instr,      // word at address pc
    output  logic   [31 : 0]    pc,
    output  logic   [0  : 0]    rf_we,      // register write trace
    output  logic   [4  : 0]    rf_wa,
    output  logic   [31 : 0]    rf_wd
);

    import nf_pkg::*;

    logic   [31 : 0]    ext_data;
    logic   [0  : 0]    src_b_sel;
    logic   [1  : 0]    src_a_sel;
    logic   [0  : 0]    shift_sel;
    logic   [0  : 0]    res_sel;
    logic   [3  : 0]    alu_code;
    logic   [4  : 0]    shamt;
    logic   [4  : 0]    ra1;
    logic   [4  : 0]    ra2;
    logic   [31 : 0]    rd1;
    logic   [31 : 0]    rd2;
    logic   [0  : 0]    pc_src;
    logic   [0  : 0]    branch_src;
    logic   [31 : 0]    src_a;
    logic   [31 : 0]    src_b;
    logic   [4  : 0]    shift;
    logic   [31 : 0]    alu_result;
    logic   [31 : 0]    pc_plus4;       // also the link value
    logic   [31 : 0]    pc_target;
    logic   [31 : 0]    pc_next;

    // operand muxes
    always_comb begin
        case (src_a_sel)
            SRCA_RD1  : src_a = rd1;
            SRCA_PC   : src_a = pc;
            SRCA_ZERO : src_a = '0;
            default   : src_a = '0;
        endcase
    end

    assign src_b = src_b_sel ? ext_data : rd2;
    assign shift = shift_sel ? rd2[4 : 0] : shamt;

    // write data, alu or link
    assign pc_plus4 = pc + 32'd4;
    assign rf_wd    = res_sel ? pc_plus4 : alu_result;

    // next pc, jalr uses rd1 as base and clears bit 0
    assign pc_target = ((branch_src ? rd1 : pc) + ext_data) & ~32'h1;
    assign pc_next   = pc_src ? pc_target : pc_plus4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;                  // one instruction per cycle
        end
    end

    nf_i_du
    nf_i_du_0
    (
        .instr      ( instr         ),
        .rd1        ( rd1           ),
        .rd2        ( rd2           ),
        .ext_data   ( ext_data      ),
        .src_b_sel  ( src_b_sel     ),
        .src_a_sel  ( src_a_sel     ),
        .shift_sel  ( shift_sel     ),
        .res_sel    ( res_sel       ),
        .alu_code   ( alu_code      ),
        .shamt      ( shamt         ),
        .ra1        ( ra1           ),
        .ra2        ( ra2           ),
        .wa3        ( rf_wa         ),      // write address goes straight to trace
        .pc_src     ( pc_src        ),
        .we_rf      ( rf_we         ),
        .branch_src ( branch_src    )
    );

    nf_alu
    nf_alu_0
    (
        .src_a      ( src_a         ),
        .src_b      ( src_b         ),
        .shift      ( shift         ),
        .alu_code   ( alu_code      ),
        .result     ( alu_result    )
    );

    nf_reg_file
    nf_reg_file_0
    (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .ra1        ( ra1           ),
        .rd1        ( rd1           ),
        .ra2        ( ra2           ),
        .rd2        ( rd2           ),
        .wa3        ( rf_wa         ),
        .wd3        ( rf_wd         ),
        .we3        ( rf_we         )
    );

endmodule : nf_cpu

//--- nf_cpu_asserts.sv
`timescale 1ns/1ps

module nf_cpu_asserts
(
    input   logic               clk,
    input   logic               rst_n,
    input   logic   [31 : 0]    pc,
    input   logic   [4  : 0]    ra1,
    input   logic   [31 : 0]    rd1,
    input   logic   [4  : 0]    ra2,
    input   logic   [31 : 0]    rd2
);

    import nf_pkg::*;

    // entry 0 seen through both read ports
    x0_port1_zero : assert property (@(posedge clk) disable iff (!rst_n)
                                     (ra1 == 5'd0) |-> (rd1 == 32'd0))
        else $error("register x0 read as nonzero on read port 1");

    x0_port2_zero : assert property (@(posedge clk) disable iff (!rst_n)
                                     (ra2 == 5'd0) |-> (rd2 == 32'd0))
        else $error("register x0 read as nonzero on read port 2");

    pc_aligned : assert property (@(posedge clk) disable iff (!rst_n) (pc[1 : 0] == 2'b00))
        else $error("pc is not word aligned");

    // first sampled cycle out of reset
    pc_after_reset : assert property (@(posedge clk) $rose(rst_n) |-> (pc == RESET_PC))
        else $error("pc differs from the reset value after reset release");

endmodule : nf_cpu_asserts

bind nf_cpu nf_cpu_asserts nf_cpu_asserts_0 (
    .clk    ( clk   ),
    .rst_n  ( rst_n ),
    .pc     ( pc    ),
    .ra1    ( ra1   ),
    .rd1    ( rd1   ),
    .ra2    ( ra2   ),
    .rd2    ( rd2   )
);

//--- nf_cpu_checker.sv
`timescale 1ns/1ps

module nf_cpu_checker
(
    input   logic                   clk,
    input   logic                   rst_n,
    input   logic                   check_en,       // instr is part of a test
    input   logic   [2  : 0]        test_id,
    input   nf_pkg::nf_instr_u      instr,
    input   logic   [31 : 0]        pc,
    input   logic                   rf_we,
    input   logic   [4  : 0]        rf_wa,
    input   logic   [31 : 0]        rf_wd,
    output  int                     errors,
    output  int                     checks,
    output  int                     tests_done,
    output  int                     tests_bad,
    output  logic                   done
);

    import nf_pkg::*;

    logic   [31 : 0]    regs [32];      // architectural model state
    logic   [31 : 0]    m_pc;
    int                 cur_test;       // -1 = no test open
    int                 test_errs;
    int                 test_checks;
    int                 all_errs;
    int                 all_checks;
    int                 n_done;
    int                 n_bad;

    function automatic string test_name(input int id);
        case (id)
            0       : return "alu_reg";
            1       : return "alu_imm";
            2       : return "upper";
            3       : return "branch";
            4       : return "jump";
            default : return "mixed";
        endcase
    endfunction

    // rv32i result by funct3, alt selects sub / sra
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b,
                                            input logic [4:0] sh);
        case (f3)
            3'b000  : return alt ? a - b : a + b;
            3'b001  : return a << sh;
            3'b010  : return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011  : return (a < b) ? 32'd1 : 32'd0;
            3'b100  : return a ^ b;
            3'b101  : return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'b110  : return a | b;
            default : return a & b;
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        if (exp !== act) begin
            test_errs++;
            $display("MISMATCH %s %s: expected %h actual %h", test_name(cur_test), what, exp, act);
        end
    endtask

    task automatic close_test();
        $display("test %-8s %s  checks %0d  errors %0d", test_name(cur_test),
                 (test_errs == 0) ? "PASS" : "FAIL", test_checks, test_errs);
        all_errs   += test_errs;
        all_checks += test_checks;
        n_done++;
        if (test_errs != 0) n_bad++;
        cur_test   = -1;
        errors     <= all_errs;
        checks     <= all_checks;
        tests_done <= n_done;
        tests_bad  <= n_bad;
    endtask

    // check the trace of one instruction, then retire it in the model
    task automatic step_model();
        nf_instr_u      w;
        logic   [31:0]  a;
        logic   [31:0]  b;
        logic   [31:0]  imm_i;
        logic   [31:0]  wd;
        logic   [31:0]  nxt;
        logic           we;
        logic           take;
        w     = instr;
        a     = regs[w.f.rs1];
        b     = regs[w.f.rs2];
        imm_i = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
        we    = 1'b1;
        wd    = m_pc + 32'd4;                         // link value
        nxt   = m_pc + 32'd4;
        take  = 1'b0;
        case (w.f.opcode)
            OPC_OP     : wd = ref_alu(w.f.funct3, w.f.funct7[5], a, b, b[4:0]);
            OPC_OP_IMM : wd = ref_alu(w.f.funct3, w.f.funct7[5] && (w.f.funct3 == 3'b101),
                                      a, imm_i, w.f.rs2);
            OPC_LUI    : wd = {w.u.imm_31_12, 12'h000};
            OPC_AUIPC  : wd = m_pc + {w.u.imm_31_12, 12'h000};
            OPC_JAL    : nxt = m_pc + {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12,
                                       w.j.imm_11, w.j.imm_10_1, 1'b0};
            OPC_JALR   : nxt = (a + imm_i) & ~32'h1;
            OPC_BRANCH : begin
                we = 1'b0;
                case (w.f.funct3)
                    3'b000  : take = (a == b);
                    3'b001  : take = (a != b);
                    3'b100  : take = ($signed(a) < $signed(b));
                    3'b101  : take = ($signed(a) >= $signed(b));
                    3'b110  : take = (a < b);
                    3'b111  : take = (a >= b);
                    default : take = 1'b0;
                endcase
                if (take) nxt = m_pc + {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
                                        w.b.imm_10_5, w.b.imm_4_1, 1'b0};
            end
            default    : we = 1'b0;                   // unsupported, plain pc+4
        endcase
        compare("pc", m_pc, pc);
        compare("rf_we", {31'b0, we}, {31'b0, rf_we});
        if (we) begin
            compare("rf_wa", {27'b0, w.f.rd}, {27'b0, rf_wa});
            compare("rf_wd", wd, rf_wd);
        end
        if (we && w.f.rd != 5'd0) regs[w.f.rd] = wd;  // x0 stays zero
        m_pc = nxt;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            m_pc       = RESET_PC;
            cur_test   = -1;
            all_errs   = 0;
            all_checks = 0;
            n_done     = 0;
            n_bad      = 0;
            done       <= 1'b0;
        end else begin
            if (cur_test >= 0 && (!check_en || int'(test_id) != cur_test)) begin
                close_test();
                if (!check_en) done <= 1'b1;          // stream ended
            end
            if (check_en) begin
                if (cur_test < 0) begin
                    cur_test    = int'(test_id);
                    test_errs   = 0;
                    test_checks = 0;
                end
                step_model();
            end
        end
    end

endmodule : nf_cpu_checker

//--- nf_i_du.sv
`timescale 1ns/1ps

module nf_i_du
(
    input   nf_pkg::nf_instr_u  instr,      // instruction word
    input   logic   [31 : 0]    rd1,        // register file read data 1
    input   logic   [31 : 0]    rd2,        // register file read data 2
    output  logic   [31 : 0]    ext_data,   // extended immediate
    output  logic   [0  : 0]    src_b_sel,  // alu b: rd2 or immediate
    output  logic   [1  : 0]    src_a_sel,  // alu a: rd1, pc or zero
    output  logic   [0  : 0]    shift_sel,  // shift amount: shamt or rd2
    output  logic   [0  : 0]    res_sel,    // write data: alu or pc+4
    output  logic   [3  : 0]    alu_code,   // alu operation
    output  logic   [4  : 0]    shamt,      // immediate shift amount
    output  logic   [4  : 0]    ra1,        // read address 1
    output  logic   [4  : 0]    ra2,        // read address 2
    output  logic   [4  : 0]    wa3,        // write address
    output  logic   [0  : 0]    pc_src,     // take branch or jump
    output  logic   [0  : 0]    we_rf,      // register write enable
    output  logic   [0  : 0]    branch_src  // branch base is rd1 (jalr)
);

    logic   [11 : 0]    imm_i;          // addi, jalr ...
    logic   [11 : 0]    imm_s;          // store form, kept for the extender
    logic   [11 : 0]    imm_b;          // branch offset bits 12..1
    logic   [19 : 0]    imm_u;          // lui, auipc
    logic   [19 : 0]    imm_j;          // jal offset bits 20..1
    logic   [2  : 0]    branch_type;
    logic   [0  : 0]    branch_hf;      // inverts compare
    logic   [2  : 0]    imm_src;

    // register addresses straight from the field view
    assign ra1   = instr.f.rs1;
    assign ra2   = instr.f.rs2;
    assign wa3   = instr.f.rd;
    assign shamt = instr.f.rs2;         // same bits as rs2

    // immediates reassembled from the format views
    assign imm_i = instr.i.imm_11_0;
    assign imm_s = { instr.s.imm_11_5, instr.s.imm_4_0 };
    assign imm_b = { instr.b.imm_12, instr.b.imm_11, instr.b.imm_10_5, instr.b.imm_4_1 };
    assign imm_u = instr.u.imm_31_12;
    assign imm_j = { instr.j.imm_20, instr.j.imm_19_12, instr.j.imm_11, instr.j.imm_10_1 };

    nf_control_unit
    nf_control_unit_0
    (
        .opcode         ( instr.f.opcode    ),
        .funct3         ( instr.f.funct3    ),
        .funct7         ( instr.f.funct7    ),
        .src_b_sel      ( src_b_sel         ),
        .src_a_sel      ( src_a_sel         ),
        .shift_sel      ( shift_sel         ),
        .res_sel        ( res_sel           ),
        .branch_type    ( branch_type       ),
        .branch_hf      ( branch_hf         ),
        .branch_src     ( branch_src        ),
        .we_rf          ( we_rf             ),
        .imm_src        ( imm_src           ),
        .alu_code       ( alu_code          )
    );

    nf_sign_ex
    nf_sign_ex_0
    (
        .imm_i          ( imm_i             ),
        .imm_s          ( imm_s             ),
        .imm_b          ( imm_b             ),
        .imm_u          ( imm_u             ),
        .imm_j          ( imm_j             ),
        .imm_src        ( imm_src           ),
        .imm_ex         ( ext_data          )
    );

    nf_branch_unit
    nf_branch_unit_0
    (
        .branch_type    ( branch_type       ),
        .d1             ( rd1               ),
        .d2             ( rd2               ),
        .branch_hf      ( branch_hf         ),
        .pc_src         ( pc_src            )
    );

endmodule : nf_i_du

//--- nf_pkg.sv
package nf_pkg;

    // major opcodes of the supported rv32i subset
    localparam logic [6 : 0] OPC_OP     = 7'b0110011;   // add, sub, and ... sltu
    localparam logic [6 : 0] OPC_OP_IMM = 7'b0010011;   // addi, slli ... sltiu
    localparam logic [6 : 0] OPC_LUI    = 7'b0110111;
    localparam logic [6 : 0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6 : 0] OPC_BRANCH = 7'b1100011;   // beq ... bgeu
    localparam logic [6 : 0] OPC_JAL    = 7'b1101111;
    localparam logic [6 : 0] OPC_JALR   = 7'b1100111;

    // alu operation codes
    localparam logic [3 : 0] ALU_ADD    = 4'd0;
    localparam logic [3 : 0] ALU_SUB    = 4'd1;
    localparam logic [3 : 0] ALU_AND    = 4'd2;
    localparam logic [3 : 0] ALU_OR     = 4'd3;
    localparam logic [3 : 0] ALU_XOR    = 4'd4;
    localparam logic [3 : 0] ALU_SLL    = 4'd5;
    localparam logic [3 : 0] ALU_SRL    = 4'd6;
    localparam logic [3 : 0] ALU_SRA    = 4'd7;
    localparam logic [3 : 0] ALU_SLT    = 4'd8;
    localparam logic [3 : 0] ALU_SLTU   = 4'd9;

    // branch types, help bit flips eq/lt/ltu into ne/ge/geu
    localparam logic [2 : 0] BR_NONE    = 3'd0;
    localparam logic [2 : 0] BR_EQ      = 3'd1;
    localparam logic [2 : 0] BR_LT      = 3'd2;
    localparam logic [2 : 0] BR_LTU     = 3'd3;
    localparam logic [2 : 0] BR_JUMP    = 3'd4;     // jal and jalr, always taken

    // immediate formats
    localparam logic [2 : 0] IMM_I      = 3'd0;
    localparam logic [2 : 0] IMM_S      = 3'd1;
    localparam logic [2 : 0] IMM_B      = 3'd2;
    localparam logic [2 : 0] IMM_U      = 3'd3;
    localparam logic [2 : 0] IMM_J      = 3'd4;

    // alu source a
    localparam logic [1 : 0] SRCA_RD1   = 2'd0;
    localparam logic [1 : 0] SRCA_PC    = 2'd1;     // auipc
    localparam logic [1 : 0] SRCA_ZERO  = 2'd2;     // lui

    localparam logic [31 : 0] RESET_PC  = 32'h0000_0000;

    // one instruction word, seen as fields or as one immediate format
    typedef union packed {
        struct packed {
            logic [6  : 0]  funct7;
            logic [4  : 0]  rs2;
            logic [4  : 0]  rs1;
            logic [2  : 0]  funct3;
            logic [4  : 0]  rd;
            logic [6  : 0]  opcode;
        } f;
        struct packed {
            logic [11 : 0]  imm_11_0;
            logic [19 : 0]  rs1_f3_rd_op;
        } i;
        struct packed {
            logic [6  : 0]  imm_11_5;
            logic [12 : 0]  rs2_rs1_f3;
            logic [4  : 0]  imm_4_0;
            logic [6  : 0]  opcode;
        } s;
        struct packed {
            logic [0  : 0]  imm_12;
            logic [5  : 0]  imm_10_5;
            logic [12 : 0]  rs2_rs1_f3;
            logic [3  : 0]  imm_4_1;
            logic [0  : 0]  imm_11;
            logic [6  : 0]  opcode;
        } b;
        struct packed {
            logic [19 : 0]  imm_31_12;
            logic [11 : 0]  rd_op;
        } u;
        struct packed {
            logic [0  : 0]  imm_20;
            logic [9  : 0]  imm_10_1;
            logic [0  : 0]  imm_11;
            logic [7  : 0]  imm_19_12;
            logic [11 : 0]  rd_op;
        } j;
    } nf_instr_u;

endpackage : nf_pkg

//--- nf_reg_file.sv
`timescale 1ns/1ps

module nf_reg_file
(
    input   logic   [0  : 0]    clk,
    input   logic   [0  : 0]    rst_n,
    input   logic   [4  : 0]    ra1,        // read address 1
    output  logic   [31 : 0]    rd1,
    input   logic   [4  : 0]    ra2,        // read address 2
    output  logic   [31 : 0]    rd2,
    input   logic   [4  : 0]    wa3,        // write address
    input   logic   [31 : 0]    wd3,
    input   logic   [0  : 0]    we3
);

    logic   [31 : 0]    reg_file [31 : 0];

    // async read
    assign rd1 = reg_file[ra1];
    assign rd2 = reg_file[ra2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                reg_file[i] <= '0;
            end
        end else if (we3 && (wa3 != 5'd0)) begin    // x0 never written
            reg_file[wa3] <= wd3;
        end
    end

endmodule : nf_reg_file

//--- nf_sign_ex.sv
`timescale 1ns/1ps

module nf_sign_ex
(
    input   logic   [11 : 0]    imm_i,
    input   logic   [11 : 0]    imm_s,
    input   logic   [11 : 0]    imm_b,      // offset bits 12..1
    input   logic   [19 : 0]    imm_u,
    input   logic   [19 : 0]    imm_j,      // offset bits 20..1
    input   logic   [2  : 0]    imm_src,    // format select
    output  logic   [31 : 0]    imm_ex
);

    import nf_pkg::*;

    always_comb begin
        case (imm_src)
            IMM_I   : imm_ex = { { 20 { imm_i[11] } }, imm_i };
            IMM_S   : imm_ex = { { 20 { imm_s[11] } }, imm_s };
            IMM_B   : imm_ex = { { 19 { imm_b[11] } }, imm_b, 1'b0 };  // halfword offset
            IMM_U   : imm_ex = { imm_u, 12'h000 };                     // upper 20 bits
            IMM_J   : imm_ex = { { 11 { imm_j[19] } }, imm_j, 1'b0 };
            default : imm_ex = '0;
        endcase
    end

endmodule : nf_sign_ex

//--- run.sh
#!/bin/sh
# build the cpu testbench with verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_nf_cpu -f flist.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_nf_cpu > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_nf_cpu.sv
`timescale 1ns/1ps

module tb_nf_cpu;

    import nf_pkg::*;

    localparam int          NUM_TESTS    = 6;
    localparam int          TEST_LEN     = 200;                 // instructions per test
    localparam int          RESET_CYCLES = 2;
    localparam int          TIMEOUT      = RESET_CYCLES + NUM_TESTS * TEST_LEN + 98;
    localparam logic [31:0] NOP          = 32'h0000_0013;       // addi x0, x0, 0

    logic           clk;
    logic           rst_n;
    logic   [31:0]  instr;
    logic   [31:0]  pc;
    logic           rf_we;
    logic   [4:0]   rf_wa;
    logic   [31:0]  rf_wd;
    logic           check_en;       // instr belongs to a test
    logic   [2:0]   test_id;
    int             errors;
    int             checks;
    int             tests_done;
    int             tests_bad;
    logic           done;           // checker closed the last test
    logic   [31:0]  lcg_state;
    logic   [4:0]   jalr_base;      // base reg of a pending jalr pair or zero
    int             cycle_cnt = 0;

    always #4 clk = ~clk;           // 8 ns period

    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper halves only since low lcg bits have short periods
    function automatic logic [31:0] rand32();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_step();
        lo = lcg_step();
        return {hi[31:16], lo[31:16]};
    endfunction

    // one legal instruction of class cls or of any class when cls is 5
    function automatic logic [31:0] make_instr(input int cls, input int idx);
        nf_instr_u      w;
        logic   [31:0]  r;
        logic   [31:0]  r2;
        logic   [31:0]  off;
        int             kind;
        r        = rand32();
        r2       = rand32();
        w        = '0;
        w.f.rd     = r[4:0];
        w.f.rs1    = r[9:5];
        w.f.rs2    = r[14:10];
        w.f.funct3 = r[17:15];
        kind     = cls;
        if (jalr_base != 5'd0) begin
            kind = 4;                                   // finish the pair first
        end else if (cls == 5) begin
            kind = r[31:29] % 5;
        end
        case (kind)
            0 : begin
                if (cls == 0 && idx < 31) begin         // seed x1..x31 with data
                    w.f.rd   = idx[4:0] + 5'd1;
                    w.f.rs1  = 5'd0;
                    w.f.funct3 = 3'b000;
                    w.f.opcode = idx[0] ? OPC_LUI : OPC_OP_IMM;
                    if (idx[0]) w.u.imm_31_12 = r2[31:12];
                    else w.i.imm_11_0 = r2[11:0];
                end else begin
                    w.f.opcode = OPC_OP;
                    w.f.funct7 = ((w.f.funct3 == 3'b000 || w.f.funct3 == 3'b101) && r2[0])
                                 ? 7'b0100000 : 7'b0000000;   // sub / sra
                end
            end
            1 : begin
                w.f.opcode = OPC_OP_IMM;
                case (w.f.funct3)
                    3'b001  : w.i.imm_11_0 = {7'b0, r2[4:0]};
                    3'b101  : w.i.imm_11_0 = {1'b0, r2[5], 5'b0, r2[4:0]};  // srli / srai
                    default : w.i.imm_11_0 = r2[11:0];
                endcase
            end
            2 : begin
                w.f.opcode    = r2[0] ? OPC_LUI : OPC_AUIPC;
                w.u.imm_31_12 = r2[31:12];
            end
            3 : begin
                w.f.opcode = OPC_BRANCH;
                if (w.f.funct3[2:1] == 2'b01) w.f.funct3 = {2'b11, r2[0]};
                if (r2[4:3] == 2'b00) w.f.rs2 = w.f.rs1;  // forces equal operands
                off = {{20{r2[31]}}, r2[30:21], 2'b00};
                w.b.imm_12   = off[12];
                w.b.imm_11   = off[11];
                w.b.imm_10_5 = off[10:5];
                w.b.imm_4_1  = off[4:1];
            end
            default : begin
                if (jalr_base != 5'd0) begin
                    w.f.opcode  = OPC_JALR;
                    w.f.funct3  = 3'b000;
                    w.f.rs1     = jalr_base;
                    w.i.imm_11_0 = {r2[31:22], 1'b0, r2[0]};  // bit 0 gets cleared
                    jalr_base   = 5'd0;
                end else if (r2[1]) begin
                    w.f.opcode  = OPC_JAL;
                    off = {{12{r2[31]}}, r2[30:13], 2'b00};
                    w.j.imm_20    = off[20];
                    w.j.imm_19_12 = off[19:12];
                    w.j.imm_11    = off[11];
                    w.j.imm_10_1  = off[10:1];
                end else begin                          // aligned base via addi from x0
                    w.f.opcode  = OPC_OP_IMM;
                    w.f.funct3  = 3'b000;
                    w.f.rs1     = 5'd0;
                    w.f.rd      = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
                    w.i.imm_11_0 = {r2[31:22], 2'b00};
                    jalr_base   = w.f.rd;
                end
            end
        endcase
        return w;
    endfunction

    nf_cpu i_nf_cpu (
        .clk    ( clk   ),
        .rst_n  ( rst_n ),
        .instr  ( instr ),
        .pc     ( pc    ),
        .rf_we  ( rf_we ),
        .rf_wa  ( rf_wa ),
        .rf_wd  ( rf_wd )
    );

    nf_cpu_checker checker_0 (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .check_en   ( check_en   ),
        .test_id    ( test_id    ),
        .instr      ( instr      ),
        .pc         ( pc         ),
        .rf_we      ( rf_we      ),
        .rf_wa      ( rf_wa      ),
        .rf_wd      ( rf_wd      ),
        .errors     ( errors     ),
        .checks     ( checks     ),
        .tests_done ( tests_done ),
        .tests_bad  ( tests_bad  ),
        .done       ( done       )
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        instr     = NOP;                // addi x0 writes nothing
        check_en  = 1'b0;
        test_id   = 3'd0;
        lcg_state = 32'd5;              // seed
        jalr_base = 5'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            jalr_base = 5'd0;           // no pair crosses a test boundary
            for (int i = 0; i < TEST_LEN; i++) begin
                instr    <= make_instr(t, i);
                test_id  <= t[2:0];
                check_en <= 1'b1;
                @(posedge clk);
            end
        end
        instr    <= NOP;
        check_en <= 1'b0;
        while (!done) @(posedge clk);
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_done, tests_bad, checks, errors);
        if (errors == 0 && tests_bad == 0 && tests_done == NUM_TESTS) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_nf_cpu
